//--- rtl/decode_defines.svh
// Width and register code macros for the instruction decoder, included by the package and RTL
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// Field widths
`define DEC_OPCODE_W 8
`define DEC_REG_W    4
`define DEC_SEG_W    2

// General register ids used in address calculation
`define DEC_REG_BX   4'd3
`define DEC_REG_BP   4'd5
`define DEC_REG_SI   4'd6
`define DEC_REG_DI   4'd7

// High bit set means the register takes no part in the address
`define DEC_REG_NONE 4'd12

// Segment register ids
`define DEC_SEG_SS   2'd2
`define DEC_SEG_DS   2'd3

// With mod 00 this rm value is a plain 16-bit address, no base or index
`define DEC_RM_DIRECT 3'd6

`endif

//--- rtl/decode_pkg.sv
// Shared types of the instruction decoder, imported by the RTL modules and the checker
`include "decode_defines.svh"

package decode_pkg;

    typedef logic [`DEC_OPCODE_W-1:0] opcode_t;   // First instruction byte
    typedef logic [`DEC_REG_W-1:0]    reg_id_t;   // Bank bit, then 3-bit register
    typedef logic [`DEC_SEG_W-1:0]    seg_id_t;

    // Second instruction byte
    typedef struct packed {
        logic [1:0] mod;                          // Addressing form
        logic [2:0] regf;                         // Register or opcode extension
        logic [2:0] rm;                           // Register or memory operand
    } modrm_t;

    // Opcode table result
    typedef struct packed {
        logic    need_modrm;
        logic    need_disp;                       // Already merged with the address form
        logic    need_imm;
        logic    imm_size;                        // 0 for 8 bit, 1 for 16 bit
        logic    byte_word;                       // W field
        reg_id_t src;
        reg_id_t dst;
    } op_info_t;

    // Effective address selection
    typedef struct packed {
        reg_id_t base;
        reg_id_t index;
        seg_id_t seg;
        logic    disp_mod;                        // Address form carries a displacement
        logic    disp_wide;                       // Displacement is 16 bit
    } ea_info_t;

    // Full decoder output
    typedef struct packed {
        logic    need_modrm;
        logic    need_disp;
        logic    disp_size;                       // 0 for 8 bit, 1 for 16 bit
        logic    need_imm;
        logic    imm_size;
        logic    byte_word;
        reg_id_t src;
        reg_id_t dst;
        reg_id_t base;
        reg_id_t index;
        seg_id_t seg;
    } decode_out_t;

endpackage

//--- rtl/opcode_table.sv
// Opcode row table giving operand needs, immediate size, W field and register ids for the decode top level
module opcode_table
(
    input  decode_pkg::opcode_t  opcode,
    input  decode_pkg::modrm_t   modrm,
    input  logic                 disp_mod,
    output decode_pkg::op_info_t info
);
    import decode_pkg::*;

    reg_id_t dir_dst;                             // Destination after the D bit
    reg_id_t dir_src;                             // Source after the D bit
    reg_id_t rm_id;

    // D bit set means the reg field is the destination
    assign dir_dst = opcode[1] ? {1'b0, modrm.regf} : {1'b0, modrm.rm};
    assign dir_src = opcode[1] ? {1'b0, modrm.rm} : {1'b0, modrm.regf};

    assign rm_id = {1'b0, modrm.rm};

    always_comb
    begin
        info.need_modrm = 1'b0;
        info.need_disp  = 1'b0;
        info.need_imm   = 1'b0;
        info.imm_size   = 1'b0;
        info.src        = '0;
        info.dst        = '0;

        // MOV R IMM and the MOV/LEA block keep W in bit 3
        if (opcode[7:4] == 4'b1011 || opcode[7:2] == 6'b1000_11)
            info.byte_word = opcode[3];
        else
            info.byte_word = opcode[0];

        priority casez (opcode)
            8'b00??_?0??:                         // ADD/OR/ADC/SBB/AND/SUB/XOR/CMP R/M R
            begin
                info.need_modrm = 1'b1;
                info.need_disp  = disp_mod;
                info.dst        = dir_dst;
                info.src        = dir_src;
            end

            8'b00??_?10?:                         // Same eight rows in ACC IMM form
            begin
                info.need_imm = 1'b1;
                info.imm_size = opcode[0];
            end

            8'b0111_????:                         // Jcc short label
            begin
                info.need_disp = 1'b1;            // 8-bit relative offset
            end

            8'b1000_00??:                         // Group 1 R/M IMM
            begin
                info.need_modrm = 1'b1;
                info.need_disp  = disp_mod;
                info.need_imm   = 1'b1;
                info.imm_size   = ~opcode[1] & opcode[0]; // Sign-extended form is 8 bit
                info.dst        = rm_id;
            end

            8'b1000_010?:                         // TEST R/M R
            begin
                info.need_modrm = 1'b1;
                info.need_disp  = disp_mod;
                info.dst        = dir_dst;
                info.src        = dir_src;
            end

            8'b1000_011?:                         // XCHG R/M R
            begin
                info.need_modrm = 1'b1;
                info.need_disp  = disp_mod;
                info.dst        = dir_dst;
                info.src        = dir_src;
            end

            8'b1000_10??:                         // MOV R/M R
            begin
                info.need_modrm = 1'b1;
                info.need_disp  = disp_mod;       // Register mode has no displacement
                info.dst        = dir_dst;
                info.src        = dir_src;
            end

            8'b1000_11?0:                         // MOV R/M sreg in either direction
            begin
                info.need_modrm = 1'b1;
                info.need_disp  = disp_mod;
                info.dst        = {opcode[1], dir_dst[2:0]};  // Into sreg when bit 1 set
                info.src        = {~opcode[1], dir_src[2:0]};
            end

            8'b1000_1101:                         // LEA
            begin
                info.need_modrm = 1'b1;
                info.need_disp  = disp_mod;
                info.dst        = dir_dst;
            end

            8'b1011_????:                         // MOV R IMM
            begin
                info.need_imm = 1'b1;
                info.imm_size = opcode[3];
                info.dst      = {1'b0, opcode[2:0]};
            end

            8'b1100_000?:                         // Shift/rotate by IMM8
            begin
                info.need_modrm = 1'b1;
                info.need_disp  = disp_mod;
                info.need_imm   = 1'b1;           // Count is always one byte
                info.dst        = rm_id;
                info.src        = rm_id;
            end

            8'b1100_011?:                         // MOV IMM to R/M
            begin
                info.need_modrm = 1'b1;
                info.need_disp  = disp_mod;
                info.need_imm   = 1'b1;
                info.imm_size   = opcode[0];
                info.dst        = rm_id;
            end

            8'b1101_00??:                         // Shift/rotate by 1 or CL
            begin
                info.need_modrm = 1'b1;
                info.need_disp  = disp_mod;
                info.dst        = rm_id;
                info.src        = rm_id;
            end

            default:
            begin
                // Rows not decoded here need nothing beyond the opcode byte
                info.need_modrm = 1'b0;
                info.need_disp  = 1'b0;
            end
        endcase
    end

endmodule

//--- rtl/ea_select.sv
// Effective address register selection and displacement size from the ModR/M fields
`include "decode_defines.svh"

module ea_select
(
    input  decode_pkg::opcode_t  opcode,
    input  logic [1:0]           mod,
    input  logic [2:0]           rm,
    output decode_pkg::ea_info_t ea
);
    import decode_pkg::*;

    reg_id_t base_sel;
    reg_id_t index_sel;
    seg_id_t seg_sel;
    logic    direct;                              // Plain 16-bit address
    logic    wide_form;
    logic    wide_override;                       // Opcode forces a word displacement

    assign direct = (mod == 2'b00) && (rm == `DEC_RM_DIRECT);

    always_comb
    begin
        base_sel  = `DEC_REG_NONE;
        index_sel = `DEC_REG_NONE;
        seg_sel   = `DEC_SEG_DS;
        case (rm)
            3'd0:
            begin
                base_sel  = `DEC_REG_BX;
                index_sel = `DEC_REG_SI;
            end
            3'd1:
            begin
                base_sel  = `DEC_REG_BX;
                index_sel = `DEC_REG_DI;
            end
            3'd2:
            begin
                base_sel  = `DEC_REG_BP;
                index_sel = `DEC_REG_SI;
                seg_sel   = `DEC_SEG_SS;          // BP based forms use the stack segment
            end
            3'd3:
            begin
                base_sel  = `DEC_REG_BP;
                index_sel = `DEC_REG_DI;
                seg_sel   = `DEC_SEG_SS;
            end
            3'd4: index_sel = `DEC_REG_SI;
            3'd5: index_sel = `DEC_REG_DI;
            3'd6:
            begin
                if (!direct)
                begin
                    base_sel = `DEC_REG_BP;
                    seg_sel  = `DEC_SEG_SS;
                end
            end
            default: base_sel = `DEC_REG_BX;      // rm 7
        endcase
    end

    assign wide_form     = (mod == 2'b10) || direct;
    assign wide_override = opcode[7] & (opcode[5] | opcode[4]) & ~(opcode[6] & opcode[4]);

    assign ea = '{
        base:      base_sel,
        index:     index_sel,
        seg:       seg_sel,
        disp_mod:  (mod == 2'b01) || (mod == 2'b10) || direct,
        disp_wide: wide_form | wide_override
    };

endmodule

//--- rtl/decode.sv
// Top level of the first-stage instruction decoder, joining the opcode table and address selection
module decode
(
    input  decode_pkg::opcode_t     opcode,
    input  decode_pkg::modrm_t      modrm,
    output decode_pkg::decode_out_t result
);
    import decode_pkg::*;

    op_info_t op;
    ea_info_t ea;

    ea_select u_ea_select
    (
        .opcode (opcode),
        .mod    (modrm.mod),
        .rm     (modrm.rm),
        .ea     (ea)
    );

    opcode_table u_opcode_table
    (
        .opcode   (opcode),
        .modrm    (modrm),
        .disp_mod (ea.disp_mod),                  // Address form decides the displacement
        .info     (op)
    );

    always_comb
    begin
        result.need_modrm = op.need_modrm;
        result.need_disp  = op.need_disp;
        result.disp_size  = ea.disp_wide;
        result.need_imm   = op.need_imm;
        result.imm_size   = op.imm_size;
        result.byte_word  = op.byte_word;
        result.src        = op.src;
        result.dst        = op.dst;
        result.base       = ea.base;              // High bit set when unused
        result.index      = ea.index;
        result.seg        = ea.seg;
    end

endmodule

//--- tests/decode_checker.sv
// Decoder checker with its own model of the decode rules, compares each vector and counts errors
`include "decode_defines.svh"

module decode_checker
(
    input  logic                    clk,
    input  logic                    reset,
    input  decode_pkg::opcode_t     opcode,
    input  decode_pkg::modrm_t      modrm,
    input  decode_pkg::decode_out_t result,
    input  logic                    valid,
    input  logic                    test_done,
    input  logic [2:0]              test_id,
    input  logic                    all_done,
    output int                      error_total,
    output logic                    finished
);
    timeunit 1ns;
    timeprecision 100ps;
    import decode_pkg::*;

    int test_vectors;
    int test_errors;
    int vector_total;
    int tests_run;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1:    return "ALU R/M-R rows";
            3'd2:    return "immediate rows";
            3'd3:    return "MOV R/M R and sreg";
            3'd4:    return "displacement size sweep";
            3'd5:    return "unkept and branch rows";
            default: return "fully random";
        endcase
    endfunction

    function automatic decode_out_t expected_result(input opcode_t op, input modrm_t m);
        decode_out_t e;
        logic        disp_form;
        reg_id_t     reg_id;
        reg_id_t     rm_id;
        e         = '0;
        reg_id    = {1'b0, m.regf};
        rm_id     = {1'b0, m.rm};
        disp_form = (m.mod == 2'd1) || (m.mod == 2'd2) || (m.mod == 2'd0 && m.rm == 3'd6);
        if (op inside {[8'hB0:8'hBF], [8'h8C:8'h8F]})
            e.byte_word = op[3];
        else
            e.byte_word = op[0];
        if ((op < 8'h40 && !op[2]) || op inside {[8'h84:8'h8B], 8'h8D})
        begin
            e.need_modrm = 1'b1;
            e.need_disp  = disp_form && (m.mod != 2'd3);
            e.dst        = op[1] ? reg_id : rm_id;   // D bit picks the destination
            e.src        = (op == 8'h8D) ? 4'd0 : (op[1] ? rm_id : reg_id);
        end
        else if (op < 8'h40 && op[2:1] == 2'b10)
        begin
            e.need_imm = 1'b1;
            e.imm_size = op[0];
        end
        else if (op[7:4] == 4'h7)
            e.need_disp = 1'b1;
        else if (op inside {8'h8C, 8'h8E})
        begin
            e.need_modrm = 1'b1;
            e.need_disp  = disp_form && (m.mod != 2'd3);
            e.dst        = op[1] ? {1'b1, m.regf} : rm_id;
            e.src        = op[1] ? rm_id : {1'b1, m.regf};
        end
        else if (op[7:4] == 4'hB)
        begin
            e.need_imm = 1'b1;
            e.imm_size = op[3];
            e.dst      = {1'b0, op[2:0]};
        end
        else if (op inside {[8'h80:8'h83], 8'hC0, 8'hC1, 8'hC6, 8'hC7, [8'hD0:8'hD3]})
        begin
            e.need_modrm = 1'b1;
            e.need_disp  = disp_form;
            e.dst        = rm_id;
            e.need_imm   = !(op inside {[8'hD0:8'hD3]});
            if (op[7:2] == 6'b100000)
                e.imm_size = !op[1] && op[0];     // Sign-extended form is one byte
            else if (op inside {8'hC6, 8'hC7})
                e.imm_size = op[0];
            if (op inside {8'hC0, 8'hC1, [8'hD0:8'hD3]})
                e.src = rm_id;                    // Shifts read and write the same operand
        end
        case (m.rm)
            3'd0: {e.base, e.index, e.seg} = {`DEC_REG_BX, `DEC_REG_SI, `DEC_SEG_DS};
            3'd1: {e.base, e.index, e.seg} = {`DEC_REG_BX, `DEC_REG_DI, `DEC_SEG_DS};
            3'd2: {e.base, e.index, e.seg} = {`DEC_REG_BP, `DEC_REG_SI, `DEC_SEG_SS};
            3'd3: {e.base, e.index, e.seg} = {`DEC_REG_BP, `DEC_REG_DI, `DEC_SEG_SS};
            3'd4: {e.base, e.index, e.seg} = {`DEC_REG_NONE, `DEC_REG_SI, `DEC_SEG_DS};
            3'd5: {e.base, e.index, e.seg} = {`DEC_REG_NONE, `DEC_REG_DI, `DEC_SEG_DS};
            3'd6:
            begin
                if (m.mod == 2'd0)
                    {e.base, e.index, e.seg} = {`DEC_REG_NONE, `DEC_REG_NONE, `DEC_SEG_DS};
                else
                    {e.base, e.index, e.seg} = {`DEC_REG_BP, `DEC_REG_NONE, `DEC_SEG_SS};
            end
            default: {e.base, e.index, e.seg} = {`DEC_REG_BX, `DEC_REG_NONE, `DEC_SEG_DS};
        endcase
        e.disp_size = (m.mod == 2'd2) || (m.mod == 2'd0 && m.rm == 3'd6)
                   || (op[7] && (op[5] || op[4]) && !(op[6] && op[4]));
        return e;
    endfunction

    task automatic compare_field(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (exp !== act)
        begin
            $display("Mismatch at %0d ns: %s expected %0h got %0h", $time, name, exp, act);
            test_errors = test_errors + 1;
        end
    endtask

    task automatic check_vector();
        decode_out_t e;
        e = expected_result(opcode, modrm);
        compare_field("need_modrm", 4'(e.need_modrm), 4'(result.need_modrm));
        compare_field("need_disp", 4'(e.need_disp), 4'(result.need_disp));
        compare_field("disp_size", 4'(e.disp_size), 4'(result.disp_size));
        compare_field("need_imm", 4'(e.need_imm), 4'(result.need_imm));
        compare_field("imm_size", 4'(e.imm_size), 4'(result.imm_size));
        compare_field("byte_word", 4'(e.byte_word), 4'(result.byte_word));
        compare_field("src", e.src, result.src);
        compare_field("dst", e.dst, result.dst);
        compare_field("base", e.base, result.base);
        compare_field("index", e.index, result.index);
        compare_field("seg", 4'(e.seg), 4'(result.seg));
        test_vectors = test_vectors + 1;
    endtask

    initial
    begin
        error_total  = 0;
        finished     = 1'b0;
        test_vectors = 0;
        test_errors  = 0;
        vector_total = 0;
        tests_run    = 0;
        forever
        begin
            @(negedge clk);                       // Inputs and result are stable here
            if (!reset && valid)
                check_vector();
            if (!reset && test_done)
            begin
                $display("Test %0d %s: %0d vectors, %0d errors, %s", test_id,
                         test_name(test_id), test_vectors, test_errors,
                         (test_errors == 0) ? "passed" : "FAILED");
                tests_run    = tests_run + 1;
                vector_total = vector_total + test_vectors;
                error_total  = error_total + test_errors;
                test_vectors = 0;
                test_errors  = 0;
            end
            if (!reset && all_done && !finished)
            begin
                $display("Totals: %0d tests, %0d vectors, %0d errors", tests_run,
                         vector_total, error_total);
                finished = 1'b1;
            end
        end
    end

endmodule

//--- tests/tb_decode.sv
// Testbench top for the instruction decoder, drives LCG stimulus per test and reports the result
module tb_decode;
    timeunit 1ns;
    timeprecision 100ps;
    import decode_pkg::*;

    localparam int N_ALU    = 160;
    localparam int N_IMM    = 160;
    localparam int N_MOV    = 96;
    localparam int N_SWEEP  = 128;                // 4 opcodes x 32 mod/rm pairs
    localparam int N_UNKEPT = 200;
    localparam int N_BRANCH = 16;
    localparam int N_RANDOM = 2000;
    localparam int N_TOTAL  = N_ALU + N_IMM + N_MOV + N_SWEEP + N_UNKEPT + N_BRANCH + N_RANDOM;
    localparam int WATCHDOG_NS = (N_TOTAL + 20) * 40;

    logic        clk = 1'b0;
    logic        reset;
    opcode_t     opcode;
    modrm_t      modrm;
    decode_out_t result;
    logic        valid;
    logic        test_done;
    logic        all_done;
    logic        finished;
    logic [2:0]  test_id;
    int          errors;
    logic [31:0] lcg_state = 32'h6e95;

    always #20 clk = ~clk;                        // 40 ns period

    decode uut
    (
        .opcode (opcode),
        .modrm  (modrm),
        .result (result)
    );

    decode_checker u_checker
    (
        .clk         (clk),
        .reset       (reset),
        .opcode      (opcode),
        .modrm       (modrm),
        .result      (result),
        .valid       (valid),
        .test_done   (test_done),
        .test_id     (test_id),
        .all_done    (all_done),
        .error_total (errors),
        .finished    (finished)
    );

    function logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Opcode rows with an immediate operand, picked by the low bits
    function automatic opcode_t imm_row_opcode(input logic [31:0] r);
        case (r[2:0])
            3'd0, 3'd6: return {2'b00, r[5:3], 2'b10, r[6]};   // ACC IMM
            3'd1:       return {6'b100000, r[4:3]};
            3'd2, 3'd7: return {4'b1011, r[6:3]};
            3'd3:       return {7'b1100011, r[3]};
            3'd4:       return {7'b1100000, r[3]};
            default:    return {6'b110100, r[4:3]};            // Shift by 1 or CL, no immediate
        endcase
    endfunction

    function automatic opcode_t mov_opcode(input logic [2:0] k);
        case (k)
            3'd0:       return 8'h88;
            3'd1:       return 8'h89;
            3'd2:       return 8'h8A;
            3'd3:       return 8'h8B;
            3'd4, 3'd6: return 8'h8C;
            default:    return 8'h8E;
        endcase
    endfunction

    function automatic logic is_kept_row(input opcode_t op);
        logic alu;
        alu = (op[7:6] == 2'b00) && (op[2] == 1'b0 || op[2:1] == 2'b10);
        return alu || op[7:4] == 4'h7 || op[7:4] == 4'hB || (op[7:4] == 4'h8 && op != 8'h8F)
            || op == 8'hC0 || op == 8'hC1 || op == 8'hC6 || op == 8'hC7 || op[7:2] == 6'b110100;
    endfunction

    task automatic apply_vector(input logic [2:0] id, input opcode_t op, input modrm_t mrm);
        @(posedge clk);
        opcode    <= op;
        modrm     <= mrm;
        test_id   <= id;
        valid     <= 1'b1;
        test_done <= 1'b0;
    endtask

    task automatic finish_test();
        @(posedge clk);
        valid     <= 1'b0;
        test_done <= 1'b1;                        // Checker prints the status line
    endtask

    initial
    begin
        logic [31:0] r;
        logic [31:0] m;
        opcode_t     op;
        reset     <= 1'b1;
        opcode    <= '0;
        modrm     <= '0;
        valid     <= 1'b0;
        test_done <= 1'b0;
        all_done  <= 1'b0;
        test_id   <= 3'd0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < N_ALU; i++)
        begin
            r = next_rand();
            m = next_rand();
            apply_vector(3'd1, {2'b00, r[31:29], 1'b0, r[28:27]}, m[31:24]);
        end
        finish_test();
        for (int i = 0; i < N_IMM; i++)
        begin
            r = next_rand();
            m = next_rand();
            apply_vector(3'd2, imm_row_opcode(r[31:0] >> 24), m[31:24]);
        end
        finish_test();
        for (int i = 0; i < N_MOV; i++)
        begin
            r = next_rand();
            m = next_rand();
            apply_vector(3'd3, mov_opcode(r[31:29]), {r[28] ? 2'b11 : m[31:30], m[29:24]});
        end
        finish_test();
        // 0x01 and 0xD1 have no wide override, 0xB8 and 0x90 have it
        for (int k = 0; k < 4; k++)
        begin
            op = (k == 0) ? 8'h01 : (k == 1) ? 8'hD1 : (k == 2) ? 8'hB8 : 8'h90;
            for (int mr = 0; mr < 32; mr++)
            begin
                r = next_rand();
                apply_vector(3'd4, op, {mr[4:3], r[31:29], mr[2:0]});
            end
        end
        finish_test();
        for (int i = 0; i < N_UNKEPT; i++)
        begin
            do
                r = next_rand();
            while (is_kept_row(r[31:24]));
            m = next_rand();
            apply_vector(3'd5, r[31:24], m[31:24]);
        end
        for (int i = 0; i < N_BRANCH; i++)
        begin
            m = next_rand();
            apply_vector(3'd5, {4'b0111, i[3:0]}, m[31:24]);
        end
        finish_test();
        for (int i = 0; i < N_RANDOM; i++)
        begin
            r = next_rand();
            m = next_rand();
            apply_vector(3'd6, r[31:24], m[31:24]);
        end
        finish_test();
        @(posedge clk);
        test_done <= 1'b0;
        all_done  <= 1'b1;
        wait (finished);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- project.f
+incdir+rtl
rtl/decode_pkg.sv
rtl/opcode_table.sv
rtl/ea_select.sv
rtl/decode.sv
tests/decode_checker.sv
tests/tb_decode.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_decode
FILELIST   := project.f
TIMESCALE  := --timescale 1ns/100ps
LINT_FLAGS := --lint-only --timing $(TIMESCALE)
SIM_FLAGS  := --binary --timing $(TIMESCALE)
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_TEXT  := Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
